/* node_queue.sv */
// Circular node queue with valid flags, content search and in-place count update
`timescale 1ns/1ps
`default_nettype none

module node_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  logic                        push,
    input  logic                        pop,
    input  logic                        update,
    input  path_count_pkg::queue_entry_t push_entry,
    input  path_count_pkg::node_t       search_node,
    input  path_count_pkg::count_t      update_count,
    output path_count_pkg::queue_entry_t head,
    output path_count_pkg::count_t      hit_count,
    output logic                        hit,
    output logic                        empty
);

    import path_count_pkg::*;

    queue_entry_t            entries [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0]  valid;
    logic [QUEUE_PTR_W-1:0]  wr_ptr;
    logic [QUEUE_PTR_W-1:0]  rd_ptr;
    logic [QUEUE_PTR_W-1:0]  push_slot;
    logic [QUEUE_PTR_W-1:0]  hit_idx;

    // A push together with clear lands in slot 0
    assign push_slot = clear ? '0 : wr_ptr;

    // Slot 0 stands in for all flags when the pointers meet
    assign empty = (wr_ptr == rd_ptr) && !valid[0];

    assign head = entries[rd_ptr];

    // Pointers and valid flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid  <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear) begin
            valid  <= '0;
            rd_ptr <= '0;
            if (push) begin
                valid[0] <= 1'b1;
                wr_ptr   <= QUEUE_PTR_W'(1);
            end else begin
                wr_ptr <= '0;
            end
        end else if (push) begin
            valid[wr_ptr] <= 1'b1;
            wr_ptr        <= wr_ptr + 1'b1;
        end else if (pop) begin
            // Popped node drops out of the presence search
            valid[rd_ptr] <= 1'b0;
            rd_ptr        <= rd_ptr + 1'b1;
        end
    end

    // Slot contents
    always_ff @(posedge clk) begin
        if (push) begin
            entries[push_slot] <= push_entry;
        end else if (update) begin
            entries[hit_idx].count <= update_count;
        end
    end

    // Presence search over the valid slots
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (valid[i] && (entries[i].node == search_node)) begin
                hit     = 1'b1;
                hit_idx = QUEUE_PTR_W'(i);
            end
        end
    end

    assign hit_count = entries[hit_idx].count;

endmodule

`default_nettype wire

/* path_accum.sv */
// Path-count adder with selected operands, popped-count register and end-node accumulator
`timescale 1ns/1ps
`default_nettype none

module path_accum (
    input  logic                   clk,
    input  logic                   rst_n,
    input  path_count_pkg::op_sel_t op_sel,
    input  logic                   load_start,
    input  logic                   take_pop,
    input  logic                   write_end,
    input  path_count_pkg::count_t head_count,
    input  path_count_pkg::count_t hit_count,
    output path_count_pkg::count_t sum,
    output path_count_pkg::count_t ans
);

    import path_count_pkg::*;

    count_t pop_count;
    count_t end_acc;
    count_t op_a;
    count_t op_b;

    // First operand
    always_comb begin
        case (op_sel)
            ZERO:      op_a = '0;
            END_ACC:   op_a = end_acc;
            QUEUE_HIT: op_a = hit_count;
            default:   op_a = '0;
        endcase
    end

    // Start node seeds one path, every successor inherits the popped count
    assign op_b = load_start ? count_t'(1) : pop_count;

    // Wraps modulo 2^COUNT_W
    assign sum = op_a + op_b;

    always_ff @(posedge clk) begin
        if (take_pop) begin
            pop_count <= head_count;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            end_acc <= '0;
        end else if (load_start) begin
            end_acc <= '0;
        end else if (write_end) begin
            end_acc <= sum;
        end
    end

    assign ans = end_acc;

endmodule

`default_nettype wire

/* path_count_ctrl.sv */
// Control FSM sequencing the start push, queue pops, successor handling and done
`timescale 1ns/1ps
`default_nettype none

module path_count_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  path_count_pkg::node_t        start_node,
    input  path_count_pkg::node_t        end_node,
    input  path_count_pkg::edge_t        edge_in,
    input  logic                         empty,
    input  logic                         hit,
    input  path_count_pkg::queue_entry_t head,
    output logic                         clear,
    output logic                         push,
    output logic                         pop,
    output logic                         update,
    output logic                         load_start,
    output logic                         take_pop,
    output logic                         write_end,
    output path_count_pkg::op_sel_t      op_sel,
    output path_count_pkg::node_t        push_node,
    output path_count_pkg::node_t        node_idx,
    output logic                         node_load,
    output logic                         edge_take,
    output logic                         done
);

    import path_count_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        finish;

    // Queue ran dry at pop, the end accumulator holds the answer
    assign finish = (state == POP) && empty;

    always_comb begin
        clear      = 1'b0;
        push       = 1'b0;
        pop        = 1'b0;
        update     = 1'b0;
        load_start = 1'b0;
        take_pop   = 1'b0;
        write_end  = 1'b0;
        edge_take  = 1'b0;
        op_sel     = ZERO;
        push_node  = edge_in.dst;
        state_nxt  = state;

        case (state)
            IDLE, DONE: begin
                if (start) begin
                    // Fresh queue seeded with the start node and a count of one
                    clear      = 1'b1;
                    push       = 1'b1;
                    load_start = 1'b1;
                    push_node  = start_node;
                    state_nxt  = POP;
                end
            end
            POP: begin
                if (empty) begin
                    state_nxt = DONE;
                end else begin
                    pop       = 1'b1;
                    take_pop  = 1'b1;
                    state_nxt = EDGE;
                end
            end
            EDGE: begin
                // left of zero means a node without successors
                if (edge_in.left != '0) begin
                    edge_take = 1'b1;
                    if (edge_in.dst == end_node) begin
                        op_sel    = END_ACC;
                        write_end = 1'b1;
                    end else if (hit) begin
                        // Merge into the waiting entry
                        op_sel = QUEUE_HIT;
                        update = 1'b1;
                    end else begin
                        push = 1'b1;
                    end
                end
                if (edge_in.left <= DEGREE_W'(1)) begin
                    state_nxt = POP;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            node_idx  <= '0;
            node_load <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= state_nxt;
            // node_load marks the first cycle of a new node_idx
            node_load <= pop;
            if (pop) begin
                node_idx <= head.node;
            end
            if (load_start) begin
                done <= 1'b0;
            end else if (finish) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* path_count_pkg.sv */
// Shared widths, queue depth, FSM encoding and bus structs, imported by every RTL file
`default_nettype none

package path_count_pkg;

    // Data widths
    localparam int NODE_W   = 10;
    localparam int COUNT_W  = 24;
    localparam int DEGREE_W = 5;

    // Queue geometry
    localparam int QUEUE_DEPTH = 32;
    localparam int QUEUE_PTR_W = 5;

    typedef logic [NODE_W-1:0]  node_t;
    typedef logic [COUNT_W-1:0] count_t;

    // One queue slot, a node and the paths found so far that reach it
    typedef struct packed {
        node_t  node;
        count_t count;
    } queue_entry_t;

    // Successor presented by the graph source
    // left counts the successors not yet taken, including dst
    typedef struct packed {
        node_t               dst;
        logic [DEGREE_W-1:0] left;
    } edge_t;

    typedef enum logic [1:0] {
        IDLE,
        POP,
        EDGE,
        DONE
    } ctrl_state_t;

    // First operand of the accumulator adder
    typedef enum logic [1:0] {
        ZERO,
        END_ACC,
        QUEUE_HIT
    } op_sel_t;

endpackage

`default_nettype wire

/* path_count_top.sv */
// Path counter top level connecting controller, node queue and accumulator to the graph source
`timescale 1ns/1ps
`default_nettype none

module path_count_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  path_count_pkg::node_t  start_node,
    input  path_count_pkg::node_t  end_node,
    input  path_count_pkg::edge_t  edge_in,
    output path_count_pkg::node_t  node_idx,
    output logic                   node_load,
    output logic                   edge_take,
    output path_count_pkg::count_t ans,
    output logic                   done
);

    import path_count_pkg::*;

    logic         clear;
    logic         push;
    logic         pop;
    logic         update;
    logic         load_start;
    logic         take_pop;
    logic         write_end;
    logic         empty;
    logic         hit;
    op_sel_t      op_sel;
    node_t        push_node;
    count_t       sum;
    count_t       hit_count;
    queue_entry_t head;
    queue_entry_t push_entry;

    // New entries carry the running sum
    assign push_entry = '{node: push_node, count: sum};

    path_count_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .start_node (start_node),
        .end_node   (end_node),
        .edge_in    (edge_in),
        .empty      (empty),
        .hit        (hit),
        .head       (head),
        .clear      (clear),
        .push       (push),
        .pop        (pop),
        .update     (update),
        .load_start (load_start),
        .take_pop   (take_pop),
        .write_end  (write_end),
        .op_sel     (op_sel),
        .push_node  (push_node),
        .node_idx   (node_idx),
        .node_load  (node_load),
        .edge_take  (edge_take),
        .done       (done)
    );

    node_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .push         (push),
        .pop          (pop),
        .update       (update),
        .push_entry   (push_entry),
        .search_node  (edge_in.dst),
        .update_count (sum),
        .head         (head),
        .hit_count    (hit_count),
        .hit          (hit),
        .empty        (empty)
    );

    path_accum u_accum (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_sel     (op_sel),
        .load_start (load_start),
        .take_pop   (take_pop),
        .write_end  (write_end),
        .head_count (head.count),
        .hit_count  (hit_count),
        .sum        (sum),
        .ans        (ans)
    );

endmodule

`default_nettype wire

/* project.f */
path_count_pkg.sv
node_queue.sv
path_accum.sv
path_count_ctrl.sv
path_count_top.sv
tb_graph_source.sv
tb_path_count.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_path_count -f project.f -o sim_path_count

output="$(./obj_dir/sim_path_count 2>&1 || true)"
printf '%s\n' "$output"

grep -qx "Done: no errors" <<< "$output"

/* tb_graph_source.sv */
// Testbench graph source that presents successors of node_idx from an adjacency table loaded by tasks
`timescale 1ns/1ps
`default_nettype none

module tb_graph_source (
    input  logic                  clk,
    input  logic                  rst_n,
    input  path_count_pkg::node_t node_idx,
    input  logic                  node_load,
    input  logic                  edge_take,
    output path_count_pkg::edge_t edge_in
);

    import path_count_pkg::*;

    localparam int GRAPH_NODES = 32;
    localparam int MAX_SUCC    = 8;

    logic [DEGREE_W-1:0] degree [GRAPH_NODES];
    node_t               succ [GRAPH_NODES][MAX_SUCC];
    logic [DEGREE_W-1:0] cursor;
    logic [DEGREE_W-1:0] pos;
    logic [DEGREE_W-1:0] node_degree;

    // A new node starts at its first successor in the same cycle
    assign pos = node_load ? '0 : cursor;

    assign node_degree = (node_idx < NODE_W'(GRAPH_NODES)) ? degree[node_idx[4:0]] : '0;

    always_comb begin
        edge_in.dst  = '0;
        edge_in.left = '0;
        if (pos < node_degree) begin
            edge_in.dst  = succ[node_idx[4:0]][pos[2:0]];
            edge_in.left = node_degree - pos;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor <= '0;
        end else if (node_load || edge_take) begin
            cursor <= pos + DEGREE_W'(edge_take);
        end
    end

    task automatic clear_graph();
        for (int i = 0; i < GRAPH_NODES; i++) begin
            degree[i] = '0;
        end
    endtask

    task automatic add_edge(input int src, input int dst);
        int slot;
        slot = int'(degree[src]);
        succ[src][slot] = node_t'(dst);
        degree[src]     = degree[src] + 1'b1;
    endtask

endmodule

`default_nettype wire

/* tb_path_count.sv */
// Testbench for the path counter, runs fixed and random graphs and checks ans against a queue model
`timescale 1ns/1ps
`default_nettype none

module tb_path_count;

    import path_count_pkg::*;

    localparam int CYCLE_LIMIT   = 40000;
    localparam int RANDOM_GRAPHS = 20;
    localparam int MAX_NODES     = 24;
    localparam int MAX_DEGREE    = 6;

    logic        clk;
    logic        rst_n;
    logic        start;
    node_t       start_node;
    node_t       end_node;
    edge_t       edge_in;
    node_t       node_idx;
    logic        node_load;
    logic        edge_take;
    count_t      ans;
    logic        done;
    logic [31:0] rng;
    int          cycles = 0;
    int          taken;
    logic        started;
    logic        done_q;
    count_t      ans_q;

    path_count_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .start_node (start_node),
        .end_node   (end_node),
        .edge_in    (edge_in),
        .node_idx   (node_idx),
        .node_load  (node_load),
        .edge_take  (edge_take),
        .ans        (ans),
        .done       (done)
    );

    tb_graph_source u_src (
        .clk       (clk),
        .rst_n     (rst_n),
        .node_idx  (node_idx),
        .node_load (node_load),
        .edge_take (edge_take),
        .edge_in   (edge_in)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_failure("Timeout: the run did not finish within the cycle limit");
        end
    end

    // Output checks on the falling edge, where every output has settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (!started) begin
                assert (!done && !node_load && !edge_take && ans == '0) else
                    stop_with_failure($sformatf(
                        "MISMATCH idle outputs: done %h node_load %h edge_take %h ans %h",
                        done, node_load, edge_take, ans));
            end
            if (node_load) begin
                taken = 0;
            end
            if (edge_take) begin
                assert (taken < int'(u_src.degree[node_idx[4:0]])) else
                    stop_with_failure($sformatf(
                        "MISMATCH edge_take: node_idx %h taken %h degree %h",
                        node_idx, taken, u_src.degree[node_idx[4:0]]));
                taken = taken + 1;
            end
            if (done_q && done) begin
                assert (ans == ans_q) else
                    stop_with_failure($sformatf("MISMATCH ans while done: got %h expected %h",
                                                ans, ans_q));
            end
            done_q = done;
            ans_q  = ans;
        end
    end

    // Reference model of the queue walk with merging and end accumulation
    task automatic model_path_count(input int src, input int dst, output count_t expected);
        int     q_node [$];
        count_t q_count [$];
        int     node;
        count_t cnt;
        int     nxt;
        int     found;
        int     max_live;
        expected = '0;
        max_live = 1;
        q_node.push_back(src);
        q_count.push_back(count_t'(1));
        while (q_node.size() > 0) begin
            node = q_node.pop_front();
            cnt  = q_count.pop_front();
            for (int k = 0; k < int'(u_src.degree[node]); k++) begin
                nxt   = int'(u_src.succ[node][k]);
                found = -1;
                for (int m = 0; m < q_node.size(); m++) begin
                    if (q_node[m] == nxt) begin
                        found = m;
                    end
                end
                if (nxt == dst) begin
                    expected = expected + cnt;
                end else if (found >= 0) begin
                    q_count[found] = q_count[found] + cnt;
                end else begin
                    q_node.push_back(nxt);
                    q_count.push_back(cnt);
                    if (q_node.size() > max_live) begin
                        max_live = q_node.size();
                    end
                end
            end
        end
        assert (max_live <= QUEUE_DEPTH) else
            stop_with_failure("Model queue grew beyond the queue depth");
    endtask

    // Forward edges only, node 0 is the start and the last node the end
    task automatic build_random_graph(output int nodes);
        int deg;
        int dst;
        u_src.clear_graph();
        rng   = xorshift32(rng);
        nodes = 3 + int'(rng % (MAX_NODES - 2));
        for (int i = 0; i < nodes - 1; i++) begin
            rng = xorshift32(rng);
            deg = int'(rng % (MAX_DEGREE + 1));
            for (int k = 0; k < deg; k++) begin
                rng = xorshift32(rng);
                dst = i + 1 + int'(rng % (nodes - 1 - i));
                u_src.add_edge(i, dst);
            end
        end
    endtask

    task automatic run_graph(input int src, input int dst, input count_t expected);
        @(negedge clk);
        start      = 1'b1;
        start_node = node_t'(src);
        end_node   = node_t'(dst);
        started    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (!done) else
            stop_with_failure($sformatf("MISMATCH done after start: got %h expected %h",
                                        done, 1'b0));
        while (!done) begin
            @(negedge clk);
        end
        assert (ans == expected) else
            stop_with_failure($sformatf("MISMATCH ans: got %h expected %h", ans, expected));
        // A few cycles in DONE for the steadiness check
        repeat (3) @(negedge clk);
    endtask

    initial begin
        int     nodes;
        count_t expected;
        rst_n      = 1'b0;
        start      = 1'b0;
        start_node = '0;
        end_node   = '0;
        started    = 1'b0;
        done_q     = 1'b0;
        ans_q      = '0;
        taken      = 0;
        rng        = 32'h435b_6e1a;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        // Chain 0, 1, 2, 3
        u_src.clear_graph();
        u_src.add_edge(0, 1);
        u_src.add_edge(1, 2);
        u_src.add_edge(2, 3);
        run_graph(0, 3, count_t'(1));

        // Diamond merging into node 3 before the end node 4
        u_src.clear_graph();
        u_src.add_edge(0, 1);
        u_src.add_edge(0, 2);
        u_src.add_edge(1, 3);
        u_src.add_edge(2, 3);
        u_src.add_edge(3, 4);
        run_graph(0, 4, count_t'(2));

        // Start node without successors
        u_src.clear_graph();
        run_graph(5, 6, count_t'(0));

        // End node out of reach
        u_src.add_edge(0, 1);
        run_graph(0, 2, count_t'(0));

        for (int g = 0; g < RANDOM_GRAPHS; g++) begin
            build_random_graph(nodes);
            model_path_count(0, nodes - 1, expected);
            run_graph(0, nodes - 1, expected);
        end

        // Fresh run after random ones
        u_src.clear_graph();
        u_src.add_edge(0, 1);
        u_src.add_edge(1, 2);
        u_src.add_edge(2, 3);
        run_graph(0, 3, count_t'(1));

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
